//--- src/elevator_pkg.sv
/* floor count, widths, timing constants and command enums
   shared by the elevator controller blocks */
`default_nettype none

package elevator_pkg;

	localparam int NUM_FLOORS = 8;
	localparam int FLOOR_W = $clog2(NUM_FLOORS);	// 3 bits for 8 floors

	localparam int TRAVEL_CYCLES = 4;	// cycles to move one floor
	localparam int DWELL_CYCLES = 5;	// cycles the door stays open
	localparam int TIMER_W = 3;	// holds the larger load minus one

	typedef logic [FLOOR_W-1:0] floor_t;
	typedef logic [NUM_FLOORS-1:0] floor_mask_t;	// one bit per floor

	// engine command, same coding as the old board
	typedef enum logic [1:0] {
		engine_idle = 2'd0,
		engine_down = 2'd1,
		engine_up   = 2'd2
	} engine_e;

	// door command
	typedef enum logic [1:0] {
		door_idle  = 2'd0,
		door_open  = 2'd1,
		door_close = 2'd2
	} door_e;

	typedef enum logic [2:0] {
		st_parked     = 3'd0,	// door shut, engine off
		st_moving     = 3'd1,	// one floor of travel in progress
		st_arrive     = 3'd2,	// stop decision at the new floor
		st_door_open  = 3'd3,
		st_door_close = 3'd4
	} car_state_e;

endpackage

`default_nettype wire

//--- src/call_register.sv
/* cab and hall request lamps with serve clearing,
   plus the above/below masks and stop flags at the car floor */
`default_nettype none

module call_register (
	input  logic                      clk,
	input  logic                      reset,
	input  elevator_pkg::floor_mask_t cab_btn,
	input  elevator_pkg::floor_mask_t up_btn,
	input  elevator_pkg::floor_mask_t down_btn,
	input  elevator_pkg::floor_t      floor,
	input  logic                      serve,
	input  logic                      served_up,
	output elevator_pkg::floor_mask_t cab_lamps,
	output elevator_pkg::floor_mask_t up_lamps,
	output elevator_pkg::floor_mask_t down_lamps,
	output logic                      calls_above,
	output logic                      calls_below,
	output logic                      stop_here_up,
	output logic                      stop_here_down,
	output logic                      any_here
);

	elevator_pkg::floor_mask_t floor_sel;	// one-hot car floor
	elevator_pkg::floor_mask_t below_mask;
	elevator_pkg::floor_mask_t above_mask;
	elevator_pkg::floor_mask_t all_lamps;
	elevator_pkg::floor_mask_t up_valid;	// no up button on the top floor
	elevator_pkg::floor_mask_t down_valid;	// no down button on floor 0
	elevator_pkg::floor_mask_t clr_cab;
	elevator_pkg::floor_mask_t clr_up;
	elevator_pkg::floor_mask_t clr_down;

	assign floor_sel  = elevator_pkg::floor_mask_t'(1) << floor;
	assign below_mask = floor_sel - elevator_pkg::floor_mask_t'(1);
	assign above_mask = ~(below_mask | floor_sel);

	assign up_valid   = ~(elevator_pkg::floor_mask_t'(1) << (elevator_pkg::NUM_FLOORS - 1));
	assign down_valid = ~elevator_pkg::floor_mask_t'(1);

	// serve clears the cab lamp and the hall lamp of the served direction
	assign clr_cab  = serve ? floor_sel : '0;
	assign clr_up   = (serve && served_up) ? floor_sel : '0;
	assign clr_down = (serve && !served_up) ? floor_sel : '0;

	// a press in the same cycle as a clear wins
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cab_lamps  <= '0;
			up_lamps   <= '0;
			down_lamps <= '0;
		end else begin
			cab_lamps  <= (cab_lamps & ~clr_cab) | cab_btn;
			up_lamps   <= (up_lamps & ~clr_up) | (up_btn & up_valid);
			down_lamps <= (down_lamps & ~clr_down) | (down_btn & down_valid);
		end
	end

	assign all_lamps = cab_lamps | up_lamps | down_lamps;

	assign calls_above = |(all_lamps & above_mask);
	assign calls_below = |(all_lamps & below_mask);
	assign any_here    = |(all_lamps & floor_sel);

	// stop flags per travel direction, opposite-hall case is left to the FSM
	assign stop_here_up   = |((cab_lamps | up_lamps) & floor_sel);
	assign stop_here_down = |((cab_lamps | down_lamps) & floor_sel);

endmodule

`default_nettype wire

//--- src/motion_timer.sv
/* shared down-counter for floor travel and door dwell */
`default_nettype none

module motion_timer (
	input  logic clk,
	input  logic reset,
	input  logic start_travel,
	input  logic start_dwell,
	input  logic cut_short,
	output logic expired
);

	logic [elevator_pkg::TIMER_W-1:0] count;
	logic active;	// an interval is running

	// load N-1 so expired sits in the Nth cycle of the interval
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count  <= '0;
			active <= 1'b0;
		end else if (start_travel) begin
			count  <= elevator_pkg::TIMER_W'(elevator_pkg::TRAVEL_CYCLES - 1);
			active <= 1'b1;
		end else if (start_dwell) begin
			count  <= elevator_pkg::TIMER_W'(elevator_pkg::DWELL_CYCLES - 1);
			active <= 1'b1;
		end else if (expired) begin
			active <= 1'b0;	// single pulse, then idle
		end else if (cut_short) begin
			count <= '0;	// expire next cycle
		end else if (active) begin
			count <= count - elevator_pkg::TIMER_W'(1);
		end
	end

	assign expired = active && (count == '0);

endmodule

`default_nettype wire

//--- src/car_position.sv
/* car floor counter and travel direction register */
`default_nettype none

module car_position (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 step,
	input  logic                 reverse,
	output elevator_pkg::floor_t floor,
	output logic                 dir_up
);

	logic at_top;
	logic at_bottom;

	assign at_top    = (floor == elevator_pkg::floor_t'(elevator_pkg::NUM_FLOORS - 1));
	assign at_bottom = (floor == '0);

	// step follows the direction held before any reverse in the same cycle
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			floor <= '0;
		end else if (step) begin
			if (dir_up && !at_top) begin
				floor <= floor + elevator_pkg::floor_t'(1);
			end else if (!dir_up && !at_bottom) begin
				floor <= floor - elevator_pkg::floor_t'(1);
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			dir_up <= 1'b1;	// start heading up from floor 0
		end else if (reverse) begin
			dir_up <= !dir_up;
		end
	end

endmodule

`default_nettype wire

//--- src/elevator_fsm.sv
/* car state machine with park and stop decisions,
   timer loads, position pulses and registered engine/door commands */
`default_nettype none

module elevator_fsm (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  open_btn,
	input  logic                  close_btn,
	input  logic                  dir_up,
	input  logic                  calls_above,
	input  logic                  calls_below,
	input  logic                  stop_here_up,
	input  logic                  stop_here_down,
	input  logic                  any_here,
	input  logic                  expired,
	output logic                  step,
	output logic                  reverse,
	output logic                  start_travel,
	output logic                  start_dwell,
	output logic                  cut_short,
	output logic                  serve,
	output logic                  served_up,
	output elevator_pkg::engine_e engine,
	output elevator_pkg::door_e   door
);

	elevator_pkg::car_state_e state;
	elevator_pkg::car_state_e state_next;
	elevator_pkg::engine_e    engine_next;
	elevator_pkg::door_e      door_next;

	logic ahead;	// requests beyond the car in its direction
	logic behind;
	logic stop_with;	// cab or same-direction hall lamp here
	logic stop_against;	// opposite hall lamp here
	elevator_pkg::engine_e engine_fwd;

	assign ahead        = dir_up ? calls_above : calls_below;
	assign behind       = dir_up ? calls_below : calls_above;
	assign stop_with    = dir_up ? stop_here_up : stop_here_down;
	assign stop_against = dir_up ? stop_here_down : stop_here_up;
	assign engine_fwd   = dir_up ? elevator_pkg::engine_up : elevator_pkg::engine_down;

	always_comb begin
		state_next   = state;
		engine_next  = engine;
		door_next    = door;
		step         = 1'b0;
		reverse      = 1'b0;
		start_travel = 1'b0;
		start_dwell  = 1'b0;
		cut_short    = 1'b0;
		serve        = 1'b0;
		served_up    = dir_up;

		case (state)
			elevator_pkg::st_parked: begin
				engine_next = elevator_pkg::engine_idle;
				door_next   = elevator_pkg::door_idle;
				if (any_here) begin
					// only the opposite hall lamp lit here means turn around first
					serve       = 1'b1;
					reverse     = !stop_with;
					served_up   = stop_with ? dir_up : !dir_up;
					start_dwell = 1'b1;
					door_next   = elevator_pkg::door_open;
					state_next  = elevator_pkg::st_door_open;
				end else if (ahead) begin
					start_travel = 1'b1;
					engine_next  = engine_fwd;
					state_next   = elevator_pkg::st_moving;
				end else if (behind) begin
					reverse      = 1'b1;
					start_travel = 1'b1;
					engine_next  = dir_up ? elevator_pkg::engine_down : elevator_pkg::engine_up;
					state_next   = elevator_pkg::st_moving;
				end else if (open_btn) begin
					start_dwell = 1'b1;	// reopen, nothing to serve
					door_next   = elevator_pkg::door_open;
					state_next  = elevator_pkg::st_door_open;
				end
			end

			elevator_pkg::st_moving: begin
				if (expired) begin
					step        = 1'b1;	// floor updates with engine going idle
					engine_next = elevator_pkg::engine_idle;
					state_next  = elevator_pkg::st_arrive;
				end
			end

			elevator_pkg::st_arrive: begin
				if (stop_with) begin
					serve       = 1'b1;
					start_dwell = 1'b1;
					door_next   = elevator_pkg::door_open;
					state_next  = elevator_pkg::st_door_open;
				end else if (stop_against && !ahead) begin
					serve       = 1'b1;
					reverse     = 1'b1;
					served_up   = !dir_up;
					start_dwell = 1'b1;
					door_next   = elevator_pkg::door_open;
					state_next  = elevator_pkg::st_door_open;
				end else if (ahead) begin
					start_travel = 1'b1;	// pass this floor
					engine_next  = engine_fwd;
					state_next   = elevator_pkg::st_moving;
				end else begin
					state_next = elevator_pkg::st_parked;
				end
			end

			elevator_pkg::st_door_open: begin
				cut_short = close_btn;
				if (expired) begin
					door_next  = elevator_pkg::door_close;
					state_next = elevator_pkg::st_door_close;
				end
			end

			elevator_pkg::st_door_close: begin
				if (open_btn) begin
					start_dwell = 1'b1;	// dwell restarts
					door_next   = elevator_pkg::door_open;
					state_next  = elevator_pkg::st_door_open;
				end else begin
					door_next  = elevator_pkg::door_idle;
					state_next = elevator_pkg::st_parked;
				end
			end

			default: begin
				engine_next = elevator_pkg::engine_idle;
				door_next   = elevator_pkg::door_idle;
				state_next  = elevator_pkg::st_parked;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= elevator_pkg::st_parked;
			engine <= elevator_pkg::engine_idle;
			door   <= elevator_pkg::door_idle;
		end else begin
			state  <= state_next;
			engine <= engine_next;
			door   <= door_next;
		end
	end

endmodule

`default_nettype wire

//--- src/elevator_top.sv
/* elevator controller top, connects request lamps, timer,
   car position and the car state machine */
`default_nettype none

module elevator_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      open_btn,
	input  logic                      close_btn,
	input  elevator_pkg::floor_mask_t cab_btn,
	input  elevator_pkg::floor_mask_t up_btn,
	input  elevator_pkg::floor_mask_t down_btn,
	output elevator_pkg::engine_e     engine,
	output elevator_pkg::door_e       door,
	output elevator_pkg::floor_t      level_display,
	output elevator_pkg::floor_mask_t cab_lamps,
	output elevator_pkg::floor_mask_t up_lamps,
	output elevator_pkg::floor_mask_t down_lamps
);

	elevator_pkg::floor_t floor;
	logic dir_up;
	logic step;
	logic reverse;
	logic start_travel;
	logic start_dwell;
	logic cut_short;
	logic expired;
	logic serve;
	logic served_up;
	logic calls_above;
	logic calls_below;
	logic stop_here_up;
	logic stop_here_down;
	logic any_here;

	assign level_display = floor;	// display shows the counter directly

	call_register u_calls (
		.clk(clk), .reset(reset),
		.cab_btn(cab_btn), .up_btn(up_btn), .down_btn(down_btn),
		.floor(floor), .serve(serve), .served_up(served_up),
		.cab_lamps(cab_lamps), .up_lamps(up_lamps), .down_lamps(down_lamps),
		.calls_above(calls_above), .calls_below(calls_below),
		.stop_here_up(stop_here_up), .stop_here_down(stop_here_down),
		.any_here(any_here)
	);

	motion_timer u_timer (
		.clk(clk), .reset(reset),
		.start_travel(start_travel), .start_dwell(start_dwell),
		.cut_short(cut_short), .expired(expired)
	);

	car_position u_position (
		.clk(clk), .reset(reset),
		.step(step), .reverse(reverse),
		.floor(floor), .dir_up(dir_up)
	);

	elevator_fsm u_fsm (
		.clk(clk), .reset(reset),
		.open_btn(open_btn), .close_btn(close_btn), .dir_up(dir_up),
		.calls_above(calls_above), .calls_below(calls_below),
		.stop_here_up(stop_here_up), .stop_here_down(stop_here_down),
		.any_here(any_here), .expired(expired),
		.step(step), .reverse(reverse),
		.start_travel(start_travel), .start_dwell(start_dwell), .cut_short(cut_short),
		.serve(serve), .served_up(served_up),
		.engine(engine), .door(door)
	);

endmodule

`default_nettype wire

//--- verif/elevator_props.sv
/* concurrent checks on lamps, engine, door and floor travel,
   bound into the elevator top level */
`default_nettype none

module elevator_props (
	input logic                      clk,
	input logic                      reset,
	input logic                      open_btn,
	input logic                      close_btn,
	input elevator_pkg::floor_mask_t cab_btn,
	input elevator_pkg::floor_mask_t up_btn,
	input elevator_pkg::floor_mask_t down_btn,
	input elevator_pkg::engine_e     engine,
	input elevator_pkg::door_e       door,
	input elevator_pkg::floor_t      level_display,
	input elevator_pkg::floor_mask_t cab_lamps,
	input elevator_pkg::floor_mask_t up_lamps,
	input elevator_pkg::floor_mask_t down_lamps,
	input logic                      dir_up
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LAMPS = 3 * elevator_pkg::NUM_FLOORS;
	localparam int DRAIN_CYCLES = elevator_pkg::NUM_FLOORS * 2
		* (elevator_pkg::TRAVEL_CYCLES + elevator_pkg::DWELL_CYCLES + 3) * 3;
	localparam elevator_pkg::floor_mask_t UP_VALID =
		~(elevator_pkg::floor_mask_t'(1) << (elevator_pkg::NUM_FLOORS - 1));
	localparam elevator_pkg::floor_mask_t DOWN_VALID = ~elevator_pkg::floor_mask_t'(1);

	int fail_count = 0;	// read by the testbench at the end
	elevator_pkg::floor_mask_t prev_cab;
	elevator_pkg::floor_mask_t prev_up;
	elevator_pkg::floor_mask_t prev_down;
	elevator_pkg::floor_mask_t fell_cab;
	elevator_pkg::floor_mask_t fell_up;
	elevator_pkg::floor_mask_t fell_down;
	elevator_pkg::floor_mask_t floor_bit;
	elevator_pkg::door_e       prev_door;
	elevator_pkg::engine_e     prev_engine;
	elevator_pkg::floor_t      prev_level;
	logic                      prev_open;
	logic                      close_d1;
	logic                      close_d2;
	int unsigned               open_run;	// door_open cycles so far
	int unsigned               eng_run;	// cycles of the same engine command
	int unsigned               age [0:LAMPS-1];
	logic [LAMPS-1:0]          lamps;
	logic                      stale;

	assign lamps     = {down_lamps, up_lamps, cab_lamps};
	assign fell_cab  = prev_cab & ~cab_lamps;
	assign fell_up   = prev_up & ~up_lamps;
	assign fell_down = prev_down & ~down_lamps;
	assign floor_bit = elevator_pkg::floor_mask_t'(1) << level_display;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			prev_cab    <= '0;
			prev_up     <= '0;
			prev_down   <= '0;
			prev_door   <= elevator_pkg::door_idle;
			prev_engine <= elevator_pkg::engine_idle;
			prev_level  <= '0;
			prev_open   <= 1'b0;
			close_d1    <= 1'b0;
			close_d2    <= 1'b0;
			open_run    <= 0;
			eng_run     <= 0;
			for (int i = 0; i < LAMPS; i++) age[i] <= 0;
		end else begin
			prev_cab    <= cab_lamps;
			prev_up     <= up_lamps;
			prev_down   <= down_lamps;
			prev_door   <= door;
			prev_engine <= engine;
			prev_level  <= level_display;
			prev_open   <= open_btn;
			close_d1    <= close_btn;
			close_d2    <= close_d1;
			open_run    <= (door == elevator_pkg::door_open) ? open_run + 1 : 0;
			if (engine == elevator_pkg::engine_idle) eng_run <= 0;
			else if (engine == prev_engine) eng_run <= eng_run + 1;
			else eng_run <= 1;
			for (int i = 0; i < LAMPS; i++) age[i] <= lamps[i] ? age[i] + 1 : 0;
		end
	end

	always_comb begin
		stale = 1'b0;
		for (int i = 0; i < LAMPS; i++) if (age[i] >= DRAIN_CYCLES) stale = 1'b1;
	end

	a_reset: assert property (@(posedge clk) !reset |-> engine == elevator_pkg::engine_idle
		&& door == elevator_pkg::door_idle && lamps == '0 && level_display == '0 && dir_up)
		else begin $error("outputs not at reset values"); fail_count++; end

	a_press: assert property (@(posedge clk) disable iff (!reset)
		((cab_lamps & $past(cab_btn)) == $past(cab_btn))
		&& ((up_lamps & $past(up_btn) & UP_VALID) == ($past(up_btn) & UP_VALID))
		&& ((down_lamps & $past(down_btn) & DOWN_VALID) == ($past(down_btn) & DOWN_VALID))
		&& !up_lamps[elevator_pkg::NUM_FLOORS-1] && !down_lamps[0])
		else begin $error("button press did not light its lamp"); fail_count++; end

	// lamps go out only as the door opens at that floor, hall lamps per direction
	a_clear: assert property (@(posedge clk) disable iff (!reset)
		|(fell_cab | fell_up | fell_down) |-> door == elevator_pkg::door_open
		&& prev_door != elevator_pkg::door_open
		&& ((fell_cab | fell_up | fell_down) & ~floor_bit) == '0
		&& (!(|fell_up) || dir_up) && (!(|fell_down) || !dir_up))
		else begin $error("lamp cleared without service"); fail_count++; end

	a_engine: assert property (@(posedge clk) disable iff (!reset)
		door != elevator_pkg::door_idle |-> engine == elevator_pkg::engine_idle)
		else begin $error("engine running with door active"); fail_count++; end

	a_travel: assert property (@(posedge clk) disable iff (!reset)
		level_display != prev_level |-> eng_run == elevator_pkg::TRAVEL_CYCLES
		&& ((prev_engine == elevator_pkg::engine_up
			&& level_display == prev_level + elevator_pkg::floor_t'(1))
		|| (prev_engine == elevator_pkg::engine_down
			&& level_display == prev_level - elevator_pkg::floor_t'(1))))
		else begin $error("floor change does not match travel"); fail_count++; end

	a_dwell: assert property (@(posedge clk) disable iff (!reset)
		prev_door == elevator_pkg::door_open && door != elevator_pkg::door_open
		|-> door == elevator_pkg::door_close && (open_run == elevator_pkg::DWELL_CYCLES
		|| (open_run < elevator_pkg::DWELL_CYCLES && close_d2)))
		else begin $error("door dwell ended early"); fail_count++; end

	a_dwell_max: assert property (@(posedge clk) disable iff (!reset)
		door == elevator_pkg::door_open |-> open_run < elevator_pkg::DWELL_CYCLES)
		else begin $error("door dwell too long"); fail_count++; end

	a_reopen: assert property (@(posedge clk) disable iff (!reset)
		prev_door == elevator_pkg::door_close
		|-> door == (prev_open ? elevator_pkg::door_open : elevator_pkg::door_idle))
		else begin $error("wrong door step after close"); fail_count++; end

	a_drain: assert property (@(posedge clk) disable iff (!reset) !stale)
		else begin $error("lamp left unserved too long"); fail_count++; end

endmodule

`default_nettype wire

//--- verif/elevator_tb.sv
/* testbench for the elevator controller, LFSR button stimulus,
   drain to idle and end-of-run check */
`default_nettype none

module elevator_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RANDOM_CYCLES = 400;
	localparam int DRAIN_CYCLES = elevator_pkg::NUM_FLOORS * 2
		* (elevator_pkg::TRAVEL_CYCLES + elevator_pkg::DWELL_CYCLES + 3) * 3;
	localparam int CYCLE_LIMIT = RANDOM_CYCLES + DRAIN_CYCLES;

	logic                      clk;
	logic                      reset;
	logic                      open_btn;
	logic                      close_btn;
	elevator_pkg::floor_mask_t cab_btn;
	elevator_pkg::floor_mask_t up_btn;
	elevator_pkg::floor_mask_t down_btn;
	elevator_pkg::engine_e     engine;
	elevator_pkg::door_e       door;
	elevator_pkg::floor_t      level_display;
	elevator_pkg::floor_mask_t cab_lamps;
	elevator_pkg::floor_mask_t up_lamps;
	elevator_pkg::floor_mask_t down_lamps;
	logic [15:0]               lfsr;
	int                        cycles = 0;
	int                        errors = 0;

	elevator_top UUT (
		.clk(clk), .reset(reset), .open_btn(open_btn), .close_btn(close_btn),
		.cab_btn(cab_btn), .up_btn(up_btn), .down_btn(down_btn),
		.engine(engine), .door(door), .level_display(level_display),
		.cab_lamps(cab_lamps), .up_lamps(up_lamps), .down_lamps(down_lamps)
	);

	bind elevator_top elevator_props u_props (
		.clk(clk), .reset(reset), .open_btn(open_btn), .close_btn(close_btn),
		.cab_btn(cab_btn), .up_btn(up_btn), .down_btn(down_btn),
		.engine(engine), .door(door), .level_display(level_display),
		.cab_lamps(cab_lamps), .up_lamps(up_lamps), .down_lamps(down_lamps),
		.dir_up(dir_up)
	);

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | {31'd0, lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("** Error %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: car still busy after %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int unsigned r;
		int unsigned kind;
		int unsigned fl;
		reset     = 1'b1;
		open_btn  = 1'b0;
		close_btn = 1'b0;
		cab_btn   = '0;
		up_btn    = '0;
		down_btn  = '0;
		lfsr      = 16'd60;
		#1 reset = 1'b0;	// negedge triggers the async reset
		repeat (10) @(posedge clk);
		#10 reset = 1'b1;

		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			@(posedge clk);
			#10;
			cab_btn  = '0;
			up_btn   = '0;
			down_btn = '0;
			take_bits(4, r);
			if (r == 0) begin	// about one press in 16 cycles
				take_bits(2, kind);
				take_bits(3, fl);
				case (kind)
					1: up_btn = elevator_pkg::floor_mask_t'(1) << fl;
					2: down_btn = elevator_pkg::floor_mask_t'(1) << fl;
					default: cab_btn = elevator_pkg::floor_mask_t'(1) << fl;
				endcase
			end
			take_bits(5, r);
			open_btn = (r == 0);
			take_bits(5, r);
			close_btn = (r == 1);
		end

		@(posedge clk);
		#10;
		cab_btn   = '0;
		up_btn    = '0;
		down_btn  = '0;
		open_btn  = 1'b0;
		close_btn = 1'b0;

		// lamps going dark marks the last request served
		do begin
			@(posedge clk);
			#10;
		end while ({cab_lamps, up_lamps, down_lamps} != '0);

		// door dwell and close run out before the car parks
		repeat (elevator_pkg::DWELL_CYCLES + 2) @(posedge clk);
		#10;

		check_value("cab_lamps", 32'(cab_lamps), 32'd0);
		check_value("up_lamps", 32'(up_lamps), 32'd0);
		check_value("down_lamps", 32'(down_lamps), 32'd0);
		check_value("engine", 32'(engine), 32'(elevator_pkg::engine_idle));
		check_value("door", 32'(door), 32'(elevator_pkg::door_idle));

		$display("errors: %0d end-of-run, %0d assertion", errors, UUT.u_props.fail_count);
		if (errors == 0 && UUT.u_props.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/elevator_pkg.sv
src/call_register.sv
src/motion_timer.sv
src/car_position.sv
src/elevator_fsm.sv
src/elevator_top.sv
verif/elevator_props.sv
verif/elevator_tb.sv

//--- run.sh
#!/bin/sh
# build the elevator testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module elevator_tb \
	-f verilog.f -o elevator_sim \
	&& ./obj_dir/elevator_sim +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -qx "Simulation passed" \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }
